//--- files.f
hw/fifo_pkg.sv
hw/fifo_mem_if.sv
hw/cdc_sync.sv
hw/fifo_write_ctrl.sv
hw/fifo_read_ctrl.sv
hw/fifo_ram.sv
hw/async_fifo_top.sv
test/async_fifo_tb.sv

//--- hw/async_fifo_top.sv
// dual-clock fifo top level
`timescale 1ns/1ps
`default_nettype none

module async_fifo_top
	import fifo_pkg::*;
#(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int DEPTH = DEFAULT_DEPTH,
	localparam int ADDR_WIDTH = $clog2(DEPTH),
	localparam int PTR_WIDTH = ADDR_WIDTH + 1
)
(
	// write domain
	input  logic                  write_clk,
	input  logic                  reset_rsync,
	input  logic                  write_en_i,
	input  logic [DATA_WIDTH-1:0] write_data_i,
	output logic                  full_o,

	// read domain
	input  logic                  read_clk_i,
	input  logic                  read_en_i,
	output logic [DATA_WIDTH-1:0] read_data_o,
	output logic                  empty_o
);

	// gray pointers crossing between the controllers
	logic [PTR_WIDTH-1:0] write_gray;
	logic [PTR_WIDTH-1:0] read_gray;

	// storage ports shared by both controllers and the ram
	fifo_mem_if #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) mem_bus ();

	////////////////////////////////////////
	// write_clk domain
	////////////////////////////////////////

	fifo_write_ctrl #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) write_ctrl (
		.write_clk    (write_clk),
		.reset_rsync  (reset_rsync),
		.write_en_i   (write_en_i),
		.write_data_i (write_data_i),
		.full_o       (full_o),
		.read_gray_i  (read_gray),
		.write_gray_o (write_gray),
		.mem          (mem_bus.writer)
	);

	////////////////////////////////////////
	// read_clk domain
	////////////////////////////////////////

	// reset goes here too, re-synchronized inside
	fifo_read_ctrl #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) read_ctrl (
		.read_clk_i   (read_clk_i),
		.reset_rsync  (reset_rsync),
		.read_en_i    (read_en_i),
		.empty_o      (empty_o),
		.read_data_o  (read_data_o),
		.write_gray_i (write_gray),
		.read_gray_o  (read_gray),
		.mem          (mem_bus.reader)
	);

	////////////////////////////////////////
	// storage, both clocks
	////////////////////////////////////////

	fifo_ram #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) ram (
		.write_clk  (write_clk),
		.read_clk_i (read_clk_i),
		.mem        (mem_bus.storage)
	);

endmodule

`default_nettype wire

//--- hw/cdc_sync.sv
// multi-bit clock-crossing synchronizer
`timescale 1ns/1ps
`default_nettype none

module cdc_sync
	import fifo_pkg::*;
#(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
)
(
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	// one register per stage, stage 0 samples the foreign domain
	logic [WIDTH-1:0] stage_q [SYNC_STAGES];

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
			begin
				stage_q[i] <= RESET_VALUE;
			end
		end
		else
		begin
			// first flop may go metastable, the rest settle it
			stage_q[0] <= data_i;
			for (int i = 1; i < SYNC_STAGES; i++)
			begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// output is the input delayed by SYNC_STAGES edges
	assign data_o = stage_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- hw/fifo_mem_if.sv
// fifo storage port bundle
`timescale 1ns/1ps
`default_nettype none

interface fifo_mem_if #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH = 4,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
);

	// write port, write_clk domain
	logic                  wr_en;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [DATA_WIDTH-1:0] wr_data;

	// read port, read_clk domain
	logic                  rd_en;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [DATA_WIDTH-1:0] rd_data;

	// write controller side
	modport writer (
		output wr_en,
		output wr_addr,
		output wr_data
	);

	// read controller side, gets the registered word back
	modport reader (
		output rd_en,
		output rd_addr,
		input  rd_data
	);

	// the ram itself
	modport storage (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_en,
		input  rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

//--- hw/fifo_pkg.sv
// dual-clock fifo shared definitions
`default_nettype none

package fifo_pkg;

	// flip-flops in each clock-crossing chain
	localparam int SYNC_STAGES = 2;

	// default word width and entry count
	localparam int DEFAULT_DATA_WIDTH = 32;
	// entry count must be a power of two, at least 2
	localparam int DEFAULT_DEPTH = 4;

	// widest pointer the gray function accepts
	localparam int MAX_PTR_WIDTH = 16;

	// binary to gray, callers keep only the low bits they need
	function automatic logic [MAX_PTR_WIDTH-1:0] gray_encode(
		input logic [MAX_PTR_WIDTH-1:0] bin_i
	);
		return bin_i ^ (bin_i >> 1);
	endfunction

endpackage

`default_nettype wire

//--- hw/fifo_ram.sv
// dual-clock fifo entry storage
`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH = 4
)
(
	input  logic        write_clk,
	input  logic        read_clk_i,
	fifo_mem_if.storage mem
);

	// one word per entry, index is the low pointer bits
	logic [DATA_WIDTH-1:0] entries [DEPTH];

	////////////////////////////////////////
	// write side
	////////////////////////////////////////

	// stored on the accepting write_clk edge
	always_ff @(posedge write_clk)
	begin
		if (mem.wr_en)
		begin
			entries[mem.wr_addr] <= mem.wr_data;
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	// registered read, holds the last word when not enabled
	// entry was written at least two read edges ago,
	// the pointer synchronizer guarantees that
	always_ff @(posedge read_clk_i)
	begin
		if (mem.rd_en)
		begin
			mem.rd_data <= entries[mem.rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- hw/fifo_read_ctrl.sv
// fifo read-side control
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl
	import fifo_pkg::*;
#(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int DEPTH = DEFAULT_DEPTH,
	localparam int ADDR_WIDTH = $clog2(DEPTH),
	localparam int PTR_WIDTH = ADDR_WIDTH + 1
)
(
	input  logic                  read_clk_i,
	input  logic                  reset_rsync,
	input  logic                  read_en_i,
	output logic                  empty_o,
	output logic [DATA_WIDTH-1:0] read_data_o,
	input  logic [PTR_WIDTH-1:0]  write_gray_i,
	output logic [PTR_WIDTH-1:0]  read_gray_o,
	fifo_mem_if.reader            mem
);

	// read-domain copy of the reset
	logic                     read_reset;

	// binary pointer addresses the ram while gray pointer crosses domains
	logic [PTR_WIDTH-1:0]     rd_ptr;
	logic [PTR_WIDTH-1:0]     rd_gray;
	logic [PTR_WIDTH-1:0]     rd_ptr_next;
	logic [MAX_PTR_WIDTH-1:0] rd_gray_next_wide;
	logic [PTR_WIDTH-1:0]     wr_gray_sync;
	logic                     read_accept;

	////////////////////////////////////////
	// reset into read_clk domain
	////////////////////////////////////////

	// plain delay of reset_rsync that asserts and releases two edges late
	// the chain itself is never cleared and only ever carries reset_rsync
	cdc_sync #(
		.WIDTH       (1),
		.RESET_VALUE (1'b1)
	) reset_sync (
		.clk_i   (read_clk_i),
		.reset_i (1'b0),
		.data_i  (reset_rsync),
		.data_o  (read_reset)
	);

	////////////////////////////////////////
	// write pointer into read_clk domain
	////////////////////////////////////////

	cdc_sync #(
		.WIDTH       (PTR_WIDTH),
		.RESET_VALUE ('0)
	) write_ptr_sync (
		.clk_i   (read_clk_i),
		.reset_i (read_reset),
		.data_i  (write_gray_i),
		.data_o  (wr_gray_sync)
	);

	////////////////////////////////////////
	// read pointers
	////////////////////////////////////////

	// a read while empty is ignored
	assign read_accept = read_en_i && !empty_o;

	assign rd_ptr_next = rd_ptr + 1'b1;
	assign rd_gray_next_wide = gray_encode(MAX_PTR_WIDTH'(rd_ptr_next));

	always_ff @(posedge read_clk_i)
	begin
		if (read_reset)
		begin
			rd_ptr  <= '0;
			rd_gray <= '0;
		end
		else if (read_accept)
		begin
			rd_ptr  <= rd_ptr_next;
			rd_gray <= rd_gray_next_wide[PTR_WIDTH-1:0];
		end
	end

	assign read_gray_o = rd_gray;

	// both pointers agree once the reader has caught up with the writer
	assign empty_o = (rd_gray == wr_gray_sync);

	////////////////////////////////////////
	// storage read request
	////////////////////////////////////////

	// keep fetching the head entry while anything is stored
	// so the accepting edge registers the word being consumed
	assign mem.rd_en   = !empty_o;
	assign mem.rd_addr = rd_ptr[ADDR_WIDTH-1:0];

	// word register lives in the ram and holds while empty
	assign read_data_o = mem.rd_data;

endmodule

`default_nettype wire

//--- hw/fifo_write_ctrl.sv
// fifo write-side control
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl
	import fifo_pkg::*;
#(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int DEPTH = DEFAULT_DEPTH,
	localparam int ADDR_WIDTH = $clog2(DEPTH),
	localparam int PTR_WIDTH = ADDR_WIDTH + 1
)
(
	input  logic                  write_clk,
	input  logic                  reset_rsync,
	input  logic                  write_en_i,
	input  logic [DATA_WIDTH-1:0] write_data_i,
	output logic                  full_o,
	input  logic [PTR_WIDTH-1:0]  read_gray_i,
	output logic [PTR_WIDTH-1:0]  write_gray_o,
	fifo_mem_if.writer            mem
);

	// top two gray bits flipped, all others equal, means full
	localparam logic [PTR_WIDTH-1:0] FULL_MASK = PTR_WIDTH'(2'b11) << (ADDR_WIDTH - 1);

	// binary pointer addresses the ram, gray pointer crosses domains
	logic [PTR_WIDTH-1:0]     wr_ptr;
	logic [PTR_WIDTH-1:0]     wr_gray;
	logic [PTR_WIDTH-1:0]     wr_ptr_next;
	logic [MAX_PTR_WIDTH-1:0] wr_gray_next_wide;
	logic [PTR_WIDTH-1:0]     rd_gray_sync;
	logic                     write_accept;

	////////////////////////////////////////
	// read pointer into write_clk domain
	////////////////////////////////////////

	cdc_sync #(
		.WIDTH       (PTR_WIDTH),
		.RESET_VALUE ('0)
	) read_ptr_sync (
		.clk_i   (write_clk),
		.reset_i (reset_rsync),
		.data_i  (read_gray_i),
		.data_o  (rd_gray_sync)
	);

	////////////////////////////////////////
	// write pointers
	////////////////////////////////////////

	// a write while full is dropped
	assign write_accept = write_en_i && !full_o;

	assign wr_ptr_next = wr_ptr + 1'b1;
	assign wr_gray_next_wide = gray_encode(MAX_PTR_WIDTH'(wr_ptr_next));

	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			wr_ptr  <= '0;
			wr_gray <= '0;
		end
		else if (write_accept)
		begin
			wr_ptr  <= wr_ptr_next;
			wr_gray <= wr_gray_next_wide[PTR_WIDTH-1:0];
		end
	end

	// gray pointer leaves straight from a register, no glitches
	assign write_gray_o = wr_gray;

	// writer has lapped the reader by exactly DEPTH entries
	assign full_o = (wr_gray == (rd_gray_sync ^ FULL_MASK));

	////////////////////////////////////////
	// storage write port
	////////////////////////////////////////

	// the ram stores on the same edge that moves the pointer
	assign mem.wr_en   = write_accept;
	assign mem.wr_addr = wr_ptr[ADDR_WIDTH-1:0];
	assign mem.wr_data = write_data_i;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the dual-clock fifo testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module async_fifo_tb \
	-f files.f -o sim_async_fifo \
	&& ./obj_dir/sim_async_fifo \
	&& echo "simulation run passed" \
	|| { echo "simulation run failed"; exit 1; }

//--- test/async_fifo_tb.sv
// dual-clock fifo testbench
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb
	import fifo_pkg::*;
();

	localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
	localparam int DEPTH = DEFAULT_DEPTH;
	localparam realtime READ_PERIOD = 11.0;
	localparam int STIM_WORDS = 256;
	localparam logic [31:0] LFSR_SEED = 32'ha3d4;

	// record opcodes in the stimulus file
	localparam logic [31:0] OP_END = 32'h0;
	localparam logic [31:0] OP_RESET = 32'h1;
	localparam logic [31:0] OP_WRITE = 32'h2;
	localparam logic [31:0] OP_FULL = 32'h3;
	localparam logic [31:0] OP_READ = 32'h4;
	localparam logic [31:0] OP_STREAM = 32'h5;

	logic                  write_clk;
	logic                  read_clk_i;
	logic                  reset_rsync;
	logic                  write_en_i;
	logic [DATA_WIDTH-1:0] write_data_i;
	logic                  full_o;
	logic                  read_en_i;
	logic [DATA_WIDTH-1:0] read_data_o;
	logic                  empty_o;

	logic [31:0] stim [STIM_WORDS];
	int          record_count;
	// separate gap sequence state for producer and consumer
	logic [31:0] wr_lfsr;
	logic [31:0] rd_lfsr;

	// unrelated 8 ns and 11 ns clocks
	always #4 write_clk = ~write_clk;
	always #(READ_PERIOD / 2.0) read_clk_i = ~read_clk_i;

	async_fifo_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) dut_i (
		.write_clk    (write_clk),
		.reset_rsync  (reset_rsync),
		.write_en_i   (write_en_i),
		.write_data_i (write_data_i),
		.full_o       (full_o),
		.read_clk_i   (read_clk_i),
		.read_en_i    (read_en_i),
		.read_data_o  (read_data_o),
		.empty_o      (empty_o)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] exp, input string what);
		if (got !== exp)
		begin
			abort_run($sformatf("FAILED at %0.1f ns: %s is %h, expected %h",
				$realtime, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			abort_run($sformatf("FAILED at %0.1f ns: %s is %b, expected %b",
				$realtime, what, got, exp));
		end
	endtask

	// galois form shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// two bits give zero to three idle cycles
	task automatic draw_gap(inout logic [31:0] state, output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++)
		begin
			state = lfsr_next(state);
			gap = (gap << 1) | int'(state[0]);
		end
	endtask

	// inputs change 1 ns after the edge of their own clock
	task automatic next_write_cycle();
		@(posedge write_clk);
		#1;
	endtask

	task automatic next_read_cycle();
		@(posedge read_clk_i);
		#1;
	endtask

	////////////////////////////////////////
	// bus activity
	////////////////////////////////////////

	// called one ns after a write edge
	// full_o only moves on write edges
	task automatic write_one(input logic [DATA_WIDTH-1:0] word);
		while (full_o)
		begin
			next_write_cycle();
		end
		write_en_i = 1'b1;
		write_data_i = word;
		next_write_cycle();
		write_en_i = 1'b0;
	endtask

	// word shows up one read cycle after the accepting edge
	task automatic read_one(input logic [DATA_WIDTH-1:0] expected, input string what);
		logic accepting;
		logic done;
		done = 1'b0;
		read_en_i = 1'b1;
		while (!done)
		begin
			// empty_o is steady between read edges
			// and this is what the next edge sees
			accepting = !empty_o;
			next_read_cycle();
			if (accepting)
			begin
				check_word(read_data_o, expected, what);
				done = 1'b1;
			end
		end
		read_en_i = 1'b0;
	endtask

	// reads a whole burst and then holds read_en_i on the empty fifo
	task automatic read_burst(input int base, input int count);
		next_read_cycle();
		for (int i = 0; i < count; i++)
		begin
			read_one(stim[base+i], "burst read data");
		end
		check_flag(empty_o, 1'b1, "empty after drain");
		read_en_i = 1'b1;
		repeat (4)
		begin
			next_read_cycle();
			check_flag(empty_o, 1'b1, "empty while reading an empty fifo");
		end
		read_en_i = 1'b0;
	endtask

	// producer and consumer run at once with random idle gaps
	task automatic stream_words(input int base, input int count);
		fork
			begin
				int gap;
				next_write_cycle();
				for (int i = 0; i < count; i++)
				begin
					draw_gap(wr_lfsr, gap);
					repeat (gap) next_write_cycle();
					write_one(stim[base+i]);
				end
			end
			begin
				int gap;
				next_read_cycle();
				for (int i = 0; i < count; i++)
				begin
					draw_gap(rd_lfsr, gap);
					repeat (gap) next_read_cycle();
					read_one(stim[base+i], "stream read data");
				end
			end
		join
	endtask

	// 3 write cycles high and then wait out the read-side release
	task automatic apply_reset();
		reset_rsync = 1'b1;
		write_en_i = 1'b0;
		read_en_i = 1'b0;
		repeat (3) next_write_cycle();
		reset_rsync = 1'b0;
		repeat (SYNC_STAGES + 2) next_read_cycle();
		repeat (SYNC_STAGES + 1) next_write_cycle();
		check_flag(full_o, 1'b0, "full after reset");
		next_read_cycle();
		check_flag(empty_o, 1'b1, "empty after reset");
	endtask

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	initial
	begin
		wait (record_count > 0);
		#(record_count * DEPTH * 40 * READ_PERIOD + 1000.0);
		abort_run($sformatf("timeout: %0d records did not finish in time", record_count));
	end

	////////////////////////////////////////
	// record replay
	////////////////////////////////////////

	initial
	begin
		int p;
		int count;
		write_clk = 1'b0;
		read_clk_i = 1'b0;
		reset_rsync = 1'b1;
		write_en_i = 1'b0;
		write_data_i = '0;
		read_en_i = 1'b0;
		wr_lfsr = LFSR_SEED;
		rd_lfsr = LFSR_SEED;
		record_count = 0;
		$readmemh("test/fifo_stimulus.txt", stim);

		// a record is an opcode and a word count followed by the words
		p = 0;
		while (p < STIM_WORDS - 1 && stim[p] != OP_END)
		begin
			record_count++;
			p += 2 + int'(stim[p+1]);
		end
		if (record_count == 0)
		begin
			abort_run("the stimulus file holds no records");
		end

		apply_reset();
		p = 0;
		while (stim[p] != OP_END)
		begin
			count = int'(stim[p+1]);
			case (stim[p])
				OP_RESET:
				begin
					next_write_cycle();
					apply_reset();
				end
				OP_WRITE:
				begin
					next_write_cycle();
					for (int i = 0; i < count; i++)
					begin
						write_one(stim[p+2+i]);
					end
				end
				OP_FULL:
				begin
					// this word must be dropped
					next_write_cycle();
					check_flag(full_o, 1'b1, "full before the dropped write");
					write_en_i = 1'b1;
					write_data_i = stim[p+2];
					next_write_cycle();
					write_en_i = 1'b0;
					check_flag(full_o, 1'b1, "full after the dropped write");
				end
				OP_READ: read_burst(p + 2, count);
				OP_STREAM: stream_words(p + 2, count);
				default: abort_run($sformatf("unknown record opcode %h at word %0d", stim[p], p));
			endcase
			p += 2 + count;
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/fifo_stimulus.txt
// dual-clock fifo stimulus, hex words for $readmemh
// record: opcode, word count, then that many data or expected words
// opcodes: 1 reset, 2 write burst, 3 write attempt while full,
// 4 read burst with expected words, 5 random-gap stream, 0 end

// burst comes back in write order
2 3 11111111 22222222 33333333
4 3 11111111 22222222 33333333

// fill to DEPTH, the attempt while full is dropped
2 4 a0a0a001 a0a0a002 a0a0a003 a0a0a004
3 1 deadbeef
4 4 a0a0a001 a0a0a002 a0a0a003 a0a0a004

// read_en held on empty consumed nothing
2 1 55aa55aa
4 1 55aa55aa

// long stream, pointers wrap several times
5 16
c0de0001 c0de0002 c0de0003 c0de0004
c0de0005 c0de0006 c0de0007 c0de0008
c0de0009 c0de000a c0de000b c0de000c
c0de000d c0de000e c0de000f c0de0010

// stored words are lost across a reset
2 3 77770001 77770002 77770003
1 0
2 2 88880001 88880002
4 2 88880001 88880002

// one more burst after the reset
2 4 f00d0001 f00d0002 f00d0003 f00d0004
4 4 f00d0001 f00d0002 f00d0003 f00d0004

0 0
